/* src/dcache_pkg.sv */
package dcache_pkg;

   // Geometry of the two-way cache
   localparam int WAYS            = 2;
   localparam int SET_WIDTH       = 4;
   localparam int NUM_SETS        = 16;
   localparam int WORD_SEL_WIDTH  = 3;
   localparam int LINE_ADDR_WIDTH = 27;
   localparam int TAG_WIDTH       = LINE_ADDR_WIDTH - SET_WIDTH;
   localparam int LINE_BYTES      = 32;
   localparam int LINE_BITS       = LINE_BYTES * 8;

   typedef logic [TAG_WIDTH-1:0] tag_t;
   typedef logic [LINE_BITS-1:0] line_t;

   // Word address seen as tag, set and word within the line
   typedef struct packed {
      tag_t                      tag;
      logic [SET_WIDTH-1:0]      index;
      logic [WORD_SEL_WIDTH-1:0] word;
   } addr_split_t;

   // Same word address seen as level-2 line address and word
   typedef struct packed {
      logic [LINE_ADDR_WIDTH-1:0] line_addr;
      logic [WORD_SEL_WIDTH-1:0]  word;
   } addr_line_t;

   typedef union packed {
      addr_split_t split;
      addr_line_t  line;
   } dcache_addr_u;

   // Zero byte enables mean a read
   typedef struct packed {
      dcache_addr_u addr;
      logic [3:0]   we;
      logic [31:0]  wdata;
   } dcache_req_t;

   typedef struct packed {
      logic [31:0] rdata;
   } dcache_rsp_t;

endpackage

/* src/l2_bus_pkg.sv */
package l2_bus_pkg;

   // Opcodes understood by the level-2 cache
   typedef enum logic [2:0] {
      L2_READ  = 3'b000,
      L2_WRITE = 3'b001
   } l2_opcode_e;

   // One request moves a whole line
   typedef struct packed {
      l2_opcode_e                             opcode;
      logic [dcache_pkg::LINE_ADDR_WIDTH-1:0] line_addr;
      dcache_pkg::line_t                      wdata;
      logic [dcache_pkg::LINE_BYTES-1:0]      wbe;
   } l2_req_t;

   // Read data comes back as a single valid pulse
   typedef struct packed {
      dcache_pkg::line_t rdata;
   } l2_rsp_t;

endpackage

/* src/dcache_line_ram.sv */
module dcache_line_ram #(
   parameter int SET_WIDTH_P = 4,
   parameter int TAG_WIDTH_P = 23
) (
   input  logic                   clk,
   input  logic [SET_WIDTH_P-1:0] index,
   input  logic                   we,
   input  logic [TAG_WIDTH_P-1:0] wtag,
   input  dcache_pkg::line_t      wline,
   output logic [TAG_WIDTH_P-1:0] rtag,
   output dcache_pkg::line_t      rline
);
   import dcache_pkg::*;

   logic [TAG_WIDTH_P-1:0] tag_mem  [2**SET_WIDTH_P];
   line_t                  line_mem [2**SET_WIDTH_P];

   // Write-first, so the lookup right after a fill sees the new line
   always_ff @(posedge clk) begin
      if (we) begin
         tag_mem[index]  <= wtag;
         line_mem[index] <= wline;
         rtag            <= wtag;
         rline           <= wline;
      end else begin
         rtag  <= tag_mem[index];
         rline <= line_mem[index];
      end
   end

endmodule

/* src/dcache_set_state.sv */
module dcache_set_state #(
   parameter int NUM_SETS_P = 16
) (
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 invalidate,
   input  logic [$clog2(NUM_SETS_P)-1:0]        look_set,
   input  dcache_pkg::tag_t                     look_tag,
   input  dcache_pkg::tag_t [dcache_pkg::WAYS-1:0] way_tags,
   input  logic                                 fill,
   input  logic                                 fill_way,
   input  logic                                 hit_seen,
   output logic                                 hit,
   output logic                                 hit_way,
   output logic                                 evict_way
);
   import dcache_pkg::*;

   logic [WAYS-1:0][NUM_SETS_P-1:0] valid;
   logic [NUM_SETS_P-1:0]           evict;
   logic [WAYS-1:0]                 hit_vec;

   // Tag compare against both ways of the looked-up set
   always_comb begin
      for (int w = 0; w < WAYS; w++) begin
         hit_vec[w] = valid[w][look_set] && (way_tags[w] == look_tag);
      end
   end

   assign hit       = |hit_vec;
   // With two ways the hitting way is just the way 1 match
   assign hit_way   = hit_vec[1];
   assign evict_way = evict[look_set];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid <= '0;
         evict <= '0;
      end else if (invalidate) begin
         valid <= '0;
         evict <= '0;
      end else begin
         if (fill) begin
            valid[fill_way][look_set] <= 1'b1;
         end
         // After a hit the other way becomes the victim
         if (hit_seen) begin
            evict[look_set] <= ~hit_way;
         end
      end
   end

endmodule

/* src/dcache_write_merge.sv */
module dcache_write_merge (
   input  dcache_pkg::line_t                       line,
   input  logic [dcache_pkg::WORD_SEL_WIDTH-1:0]   word,
   input  logic [3:0]                              be,
   input  logic [31:0]                             wdata,
   output dcache_pkg::line_t                       merged,
   output logic [dcache_pkg::LINE_BYTES-1:0]       line_be
);
   import dcache_pkg::*;

   // Only the enabled bytes of the selected word change
   always_comb begin
      merged = line;
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            merged[word*32 + b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
   end

   // Four enables per word, moved to the word's slot in the line
   assign line_be = {{(LINE_BYTES-4){1'b0}}, be} << {word, 2'b00};

endmodule

/* src/dcache_ctrl.sv */
module dcache_ctrl (
   input  logic                                    clk,
   input  logic                                    rst_n,
   input  logic                                    req_valid,
   input  dcache_pkg::dcache_req_t                 req,
   output logic                                    req_ready,
   output logic                                    rsp_valid,
   output dcache_pkg::dcache_rsp_t                 rsp,
   output logic                                    l2_req_valid,
   output l2_bus_pkg::l2_req_t                     l2_req,
   input  logic                                    l2_req_ready,
   input  logic                                    l2_rsp_valid,
   input  l2_bus_pkg::l2_rsp_t                     l2_rsp,
   output logic [dcache_pkg::SET_WIDTH-1:0]        ram_index,
   output logic [dcache_pkg::WAYS-1:0]             ram_we,
   output dcache_pkg::line_t                       ram_wline,
   input  dcache_pkg::line_t [dcache_pkg::WAYS-1:0] way_lines,
   input  logic                                    hit,
   input  logic                                    hit_way,
   input  logic                                    evict_way,
   output logic                                    fill,
   output logic                                    hit_seen,
   output dcache_pkg::dcache_addr_u                cur_addr,
   output logic [3:0]                              cur_we,
   output logic [31:0]                             cur_wdata,
   input  dcache_pkg::line_t                       merged,
   input  logic [dcache_pkg::LINE_BYTES-1:0]       line_be
);
   import dcache_pkg::*;
   import l2_bus_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_LOOKUP,
      ST_FILL_REQ,
      ST_FILL_WAIT,
      ST_FILL_WRITE,
      ST_WRITE_THRU
   } state_e;

   state_e      state;
   state_e      state_nxt;
   dcache_req_t cur_req;
   line_t       fill_line;
   line_t       hit_line;
   logic        is_write;

   assign is_write  = |cur_req.we;
   assign cur_addr  = cur_req.addr;
   assign cur_we    = cur_req.we;
   assign cur_wdata = cur_req.wdata;

   assign hit_line  = way_lines[hit_way];
   assign rsp.rdata = hit_line[cur_req.addr.line.word*32 +: 32];

   // Incoming set while a new request can be taken, latched set otherwise
   assign ram_index = req_ready ? req.addr.split.index : cur_req.addr.split.index;

   always_comb begin
      state_nxt    = state;
      req_ready    = 1'b0;
      rsp_valid    = 1'b0;
      l2_req_valid = 1'b0;
      l2_req       = '{opcode: L2_READ, line_addr: cur_req.addr.line.line_addr,
                       wdata: '0, wbe: '0};
      ram_we       = '0;
      ram_wline    = merged;
      fill         = 1'b0;
      hit_seen     = 1'b0;

      case (state)
         ST_IDLE: begin
            req_ready = 1'b1;
            if (req_valid) begin
               state_nxt = ST_LOOKUP;
            end
         end
         ST_LOOKUP: begin
            if (!hit) begin
               state_nxt = ST_FILL_REQ;
            end else if (!is_write) begin
               hit_seen  = 1'b1;
               rsp_valid = 1'b1;
               req_ready = 1'b1;
               state_nxt = req_valid ? ST_LOOKUP : ST_IDLE;
            end else begin
               // Update the stored line and start the write-through together
               hit_seen        = 1'b1;
               ram_we[hit_way] = 1'b1;
               l2_req_valid    = 1'b1;
               l2_req.opcode   = L2_WRITE;
               l2_req.wdata    = merged;
               l2_req.wbe      = line_be;
               if (l2_req_ready) begin
                  rsp_valid = 1'b1;
                  state_nxt = ST_IDLE;
               end else begin
                  state_nxt = ST_WRITE_THRU;
               end
            end
         end
         ST_FILL_REQ: begin
            l2_req_valid = 1'b1;
            if (l2_req_ready) begin
               state_nxt = ST_FILL_WAIT;
            end
         end
         ST_FILL_WAIT: begin
            if (l2_rsp_valid) begin
               state_nxt = ST_FILL_WRITE;
            end
         end
         ST_FILL_WRITE: begin
            ram_we[evict_way] = 1'b1;
            ram_wline         = fill_line;
            fill              = 1'b1;
            state_nxt         = ST_LOOKUP;
         end
         ST_WRITE_THRU: begin
            // RAM now holds the merged line, so the request stays the same
            l2_req_valid  = 1'b1;
            l2_req.opcode = L2_WRITE;
            l2_req.wdata  = merged;
            l2_req.wbe    = line_be;
            if (l2_req_ready) begin
               rsp_valid = 1'b1;
               state_nxt = ST_IDLE;
            end
         end
         default: begin
            state_nxt = ST_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= ST_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid && req_ready) begin
         cur_req <= req;
      end
      if (state == ST_FILL_WAIT && l2_rsp_valid) begin
         fill_line <= l2_rsp.rdata;
      end
   end

endmodule

/* src/dcache_top.sv */
module dcache_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    invalidate,
   input  logic                    req_valid,
   input  dcache_pkg::dcache_req_t req,
   output logic                    req_ready,
   output logic                    rsp_valid,
   output dcache_pkg::dcache_rsp_t rsp,
   output logic                    l2_req_valid,
   output l2_bus_pkg::l2_req_t     l2_req,
   input  logic                    l2_req_ready,
   input  logic                    l2_rsp_valid,
   input  l2_bus_pkg::l2_rsp_t     l2_rsp
);
   import dcache_pkg::*;

   localparam int SET_WIDTH_P = SET_WIDTH;
   localparam int TAG_WIDTH_P = TAG_WIDTH;
   localparam int NUM_SETS_P  = NUM_SETS;

   logic [SET_WIDTH-1:0]  ram_index;
   logic [WAYS-1:0]       ram_we;
   line_t                 ram_wline;
   tag_t [WAYS-1:0]       way_tags;
   line_t [WAYS-1:0]      way_lines;
   logic                  hit;
   logic                  hit_way;
   logic                  evict_way;
   logic                  fill;
   logic                  hit_seen;
   dcache_addr_u          cur_addr;
   logic [3:0]            cur_we;
   logic [31:0]           cur_wdata;
   line_t                 merged;
   logic [LINE_BYTES-1:0] line_be;

   for (genvar g = 0; g < WAYS; g++) begin : g_way
      dcache_line_ram #(
         .SET_WIDTH_P (SET_WIDTH_P),
         .TAG_WIDTH_P (TAG_WIDTH_P)
      ) i_line_ram (
         .clk   (clk),
         .index (ram_index),
         .we    (ram_we[g]),
         .wtag  (cur_addr.split.tag),
         .wline (ram_wline),
         .rtag  (way_tags[g]),
         .rline (way_lines[g])
      );
   end

   // Invalidate only acts between requests; the filled way is the one written
   dcache_set_state #(
      .NUM_SETS_P (NUM_SETS_P)
   ) i_set_state (
      .clk        (clk),
      .rst_n      (rst_n),
      .invalidate (invalidate & req_ready),
      .look_set   (cur_addr.split.index),
      .look_tag   (cur_addr.split.tag),
      .way_tags   (way_tags),
      .fill       (fill),
      .fill_way   (ram_we[1]),
      .hit_seen   (hit_seen),
      .hit        (hit),
      .hit_way    (hit_way),
      .evict_way  (evict_way)
   );

   dcache_write_merge i_write_merge (
      .line    (way_lines[hit_way]),
      .word    (cur_addr.split.word),
      .be      (cur_we),
      .wdata   (cur_wdata),
      .merged  (merged),
      .line_be (line_be)
   );

   dcache_ctrl i_ctrl (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req          (req),
      .req_ready    (req_ready),
      .rsp_valid    (rsp_valid),
      .rsp          (rsp),
      .l2_req_valid (l2_req_valid),
      .l2_req       (l2_req),
      .l2_req_ready (l2_req_ready),
      .l2_rsp_valid (l2_rsp_valid),
      .l2_rsp       (l2_rsp),
      .ram_index    (ram_index),
      .ram_we       (ram_we),
      .ram_wline    (ram_wline),
      .way_lines    (way_lines),
      .hit          (hit),
      .hit_way      (hit_way),
      .evict_way    (evict_way),
      .fill         (fill),
      .hit_seen     (hit_seen),
      .cur_addr     (cur_addr),
      .cur_we       (cur_we),
      .cur_wdata    (cur_wdata),
      .merged       (merged),
      .line_be      (line_be)
   );

endmodule

/* sim/l2_model.sv */
module l2_model #(
   parameter logic [31:0] PATTERN      = 32'h0,
   parameter int          READ_LATENCY = 3
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                stall,
   input  logic                l2_req_valid,
   input  l2_bus_pkg::l2_req_t l2_req,
   output logic                l2_req_ready,
   output logic                l2_rsp_valid,
   output l2_bus_pkg::l2_rsp_t l2_rsp,
   output int                  read_count,
   output int                  write_count
);
   timeunit 1ns;
   timeprecision 100ps;
   import dcache_pkg::*;
   import l2_bus_pkg::*;

   line_t                      mem [logic [LINE_ADDR_WIDTH-1:0]];
   logic                       pending;
   int                         countdown;
   logic [LINE_ADDR_WIDTH-1:0] pend_addr;

   // Lines never written hold their byte address XOR pattern in every word
   function automatic line_t read_line(input logic [LINE_ADDR_WIDTH-1:0] line_addr);
      line_t l;
      if (mem.exists(line_addr)) begin
         return mem[line_addr];
      end
      for (int w = 0; w < 8; w++) begin
         l[w*32 +: 32] = {line_addr, 3'(w), 2'b00} ^ PATTERN;
      end
      return l;
   endfunction

   assign l2_req_ready = !stall;

   always @(posedge clk or negedge rst_n) begin : serve
      line_t upd;
      if (!rst_n) begin
         l2_rsp_valid <= 1'b0;
         l2_rsp       <= '0;
         pending      <= 1'b0;
         countdown    <= 0;
         pend_addr    <= '0;
         read_count   <= 0;
         write_count  <= 0;
      end else begin
         l2_rsp_valid <= 1'b0;
         if (pending && countdown == 0) begin
            l2_rsp_valid <= 1'b1;
            l2_rsp.rdata <= read_line(pend_addr);
            pending      <= 1'b0;
         end else if (pending) begin
            countdown <= countdown - 1;
         end
         if (l2_req_valid && l2_req_ready && l2_req.opcode == L2_READ) begin
            pending    <= 1'b1;
            countdown  <= READ_LATENCY;
            pend_addr  <= l2_req.line_addr;
            read_count <= read_count + 1;
         end else if (l2_req_valid && l2_req_ready) begin
            // Only the enabled bytes of the line change
            upd = read_line(l2_req.line_addr);
            for (int b = 0; b < LINE_BYTES; b++) begin
               if (l2_req.wbe[b]) begin
                  upd[b*8 +: 8] = l2_req.wdata[b*8 +: 8];
               end
            end
            mem[l2_req.line_addr] = upd;
            write_count <= write_count + 1;
         end
      end
   end

endmodule

/* sim/dcache_tb.sv */
module dcache_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import dcache_pkg::*;
   import l2_bus_pkg::*;

   localparam int          CYCLE           = 100;
   localparam int          RESET_CYCLES    = 4;
   localparam int          REQ_LIMIT       = 60;
   localparam int          NUM_REQS        = 32;
   // Room for every request to use its whole limit plus the reset and invalidate cycles
   localparam int          WATCHDOG_CYCLES = NUM_REQS * REQ_LIMIT + 80;
   localparam logic [31:0] PATTERN         = 32'h5A3C_96E1;

   logic        clk      = 1'b0;
   logic        stall    = 1'b0;
   logic [15:0] lfsr     = 16'd91;
   int          held_off = 0;
   logic        rst_n;
   logic        invalidate;
   logic        req_valid;
   logic        req_ready;
   logic        rsp_valid;
   logic        bp_on;
   dcache_req_t req;
   dcache_rsp_t rsp;
   logic        l2_req_valid;
   l2_req_t     l2_req;
   logic        l2_req_ready;
   logic        l2_rsp_valid;
   l2_rsp_t     l2_rsp;
   int          l2_reads;
   int          l2_writes;
   int          mismatches;
   int          failures;
   logic [31:0] shadow [logic [29:0]];

   dcache_top i_dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .invalidate   (invalidate),
      .req_valid    (req_valid),
      .req          (req),
      .req_ready    (req_ready),
      .rsp_valid    (rsp_valid),
      .rsp          (rsp),
      .l2_req_valid (l2_req_valid),
      .l2_req       (l2_req),
      .l2_req_ready (l2_req_ready),
      .l2_rsp_valid (l2_rsp_valid),
      .l2_rsp       (l2_rsp)
   );

   l2_model #(
      .PATTERN (PATTERN)
   ) i_l2 (
      .clk          (clk),
      .rst_n        (rst_n),
      .stall        (stall),
      .l2_req_valid (l2_req_valid),
      .l2_req       (l2_req),
      .l2_req_ready (l2_req_ready),
      .l2_rsp_valid (l2_rsp_valid),
      .l2_rsp       (l2_rsp),
      .read_count   (l2_reads),
      .write_count  (l2_writes)
   );

   always #(CYCLE / 2) clk = ~clk;

   // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR bit per cycle decides whether level 2 holds off
   always @(posedge clk) begin
      stall <= bp_on & lfsr[15];
      if (bp_on) begin
         lfsr <= lfsr_next(lfsr);
      end
   end

   // Cycles in which level 2 refused a pending request
   always @(posedge clk) begin
      if (l2_req_valid && !l2_req_ready) begin
         held_off <= held_off + 1;
      end
   end

   function automatic logic [29:0] make_addr(input tag_t tag, input logic [3:0] index,
                                             input logic [2:0] word);
      return {tag, index, word};
   endfunction

   // Level 2 starts as byte address XOR pattern and the shadow keeps later writes
   function automatic logic [31:0] expected_word(input logic [29:0] addr);
      if (shadow.exists(addr)) begin
         return shadow[addr];
      end
      return {addr, 2'b00} ^ PATTERN;
   endfunction

   // One core request checked for read data and the level-2 traffic it caused
   task automatic send_request(input logic [29:0] addr, input logic [3:0] be,
                               input logic [31:0] wdata, input int exp_reads);
      int          waited;
      int          reads0;
      int          writes0;
      int          exp_writes;
      logic [31:0] want;
      waited     = 0;
      reads0     = l2_reads;
      writes0    = l2_writes;
      exp_writes = (be != 4'b0000) ? 1 : 0;
      want       = expected_word(addr);
      @(posedge clk);
      req_valid <= 1'b1;
      req       <= {addr, be, wdata};
      @(negedge clk);
      while (!req_ready && waited < REQ_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      @(posedge clk);
      req_valid <= 1'b0;
      do begin
         @(negedge clk);
         waited++;
      end while (!rsp_valid && waited < REQ_LIMIT);
      if (!rsp_valid) begin
         $display("No response to the request for word 0x%08h within %0d cycles",
                  addr, REQ_LIMIT);
         failures++;
      end else if (be == 4'b0000 && rsp.rdata !== want) begin
         $display("MISMATCH at %0t: read of 0x%08h gave 0x%08h, expected 0x%08h",
                  $time, addr, rsp.rdata, want);
         mismatches++;
      end
      for (int b = 0; b < 4; b++) begin
         if (be[b]) begin
            want[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      if (be != 4'b0000) begin
         shadow[addr] = want;
      end
      // Level-2 counters move on the edge that ends the response cycle
      @(negedge clk);
      if (l2_reads - reads0 != exp_reads) begin
         $display("MISMATCH at %0t: word 0x%08h caused %0d level-2 reads, expected %0d",
                  $time, addr, l2_reads - reads0, exp_reads);
         mismatches++;
      end
      if (l2_writes - writes0 != exp_writes) begin
         $display("MISMATCH at %0t: word 0x%08h caused %0d level-2 writes, expected %0d",
                  $time, addr, l2_writes - writes0, exp_writes);
         mismatches++;
      end
   endtask

   task automatic clear_cache();
      @(negedge clk);
      if (!req_ready) begin
         $display("Cache was busy when the invalidate pulse was due");
         failures++;
      end
      @(posedge clk);
      invalidate <= 1'b1;
      @(posedge clk);
      invalidate <= 1'b0;
   endtask

   task automatic test_read_miss_hit();
      send_request(make_addr(23'h01234, 4'd3, 3'd5), 4'b0000, '0, 1);
      send_request(make_addr(23'h01234, 4'd3, 3'd2), 4'b0000, '0, 0);
   endtask

   task automatic test_write_hit();
      logic [29:0] a;
      a = make_addr(23'h01234, 4'd3, 3'd5);
      send_request(a, 4'b0101, 32'hDEAD_BEEF, 0);
      send_request(a, 4'b0000, '0, 0);
      // Refetch shows the bytes that level 2 stored
      clear_cache();
      send_request(a, 4'b0000, '0, 1);
   endtask

   task automatic test_write_miss();
      logic [29:0] a;
      a = make_addr(23'h0BEEF, 4'd9, 3'd1);
      send_request(a, 4'b1111, 32'h1357_9BDF, 1);
      clear_cache();
      send_request(a, 4'b0000, '0, 1);
   endtask

   // X, Y and Z share set 7, so Z must push out Y
   task automatic test_replacement();
      clear_cache();
      send_request(make_addr(23'h00100, 4'd7, 3'd0), 4'b0000, '0, 1);
      send_request(make_addr(23'h00200, 4'd7, 3'd3), 4'b0000, '0, 1);
      send_request(make_addr(23'h00100, 4'd7, 3'd4), 4'b0000, '0, 0);
      send_request(make_addr(23'h00300, 4'd7, 3'd6), 4'b0000, '0, 1);
      send_request(make_addr(23'h00100, 4'd7, 3'd1), 4'b0000, '0, 0);
      send_request(make_addr(23'h00200, 4'd7, 3'd3), 4'b0000, '0, 1);
   endtask

   task automatic test_invalidate();
      logic [29:0] a;
      a = make_addr(23'h04321, 4'd12, 3'd7);
      send_request(a, 4'b0000, '0, 1);
      send_request(a, 4'b0000, '0, 0);
      clear_cache();
      send_request(a, 4'b0000, '0, 1);
   endtask

   // Same mix of reads and writes with the same level-2 counts per step
   task automatic run_mix(input tag_t base);
      clear_cache();
      send_request(make_addr(base, 4'd2, 3'd0), 4'b0000, '0, 1);
      send_request(make_addr(base, 4'd2, 3'd1), 4'b1111, {base[15:0], 16'h0A01}, 0);
      send_request(make_addr(base, 4'd2, 3'd1), 4'b0000, '0, 0);
      send_request(make_addr(base + 23'd1, 4'd5, 3'd3), 4'b0011, {base[15:0], 16'h0B02}, 1);
      send_request(make_addr(base + 23'd1, 4'd5, 3'd3), 4'b0000, '0, 0);
      send_request(make_addr(base + 23'd2, 4'd2, 3'd4), 4'b0000, '0, 1);
      send_request(make_addr(base + 23'd2, 4'd2, 3'd4), 4'b1000, {base[15:0], 16'h0C03}, 0);
      send_request(make_addr(base, 4'd2, 3'd1), 4'b0000, '0, 0);
   endtask

   task automatic test_back_pressure();
      int held0;
      run_mix(23'h10000);
      @(posedge clk);
      bp_on <= 1'b1;
      held0 = held_off;
      run_mix(23'h20000);
      @(posedge clk);
      bp_on <= 1'b0;
      if (held_off == held0) begin
         $display("Level 2 never held off a request while back-pressure was on");
         failures++;
      end
   endtask

   initial begin
      rst_n      = 1'b0;
      invalidate = 1'b0;
      req_valid  = 1'b0;
      req        = '0;
      bp_on      = 1'b0;
      mismatches = 0;
      failures   = 0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      test_read_miss_hit();
      test_write_hit();
      test_write_miss();
      test_replacement();
      test_invalidate();
      test_back_pressure();
      $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CYCLE);
      $display("Watchdog expired, the tests did not finish within %0d cycles",
               WATCHDOG_CYCLES);
      $display("Checks failed");
      $finish;
   end

endmodule

/* verilog.f */
src/dcache_pkg.sv
src/l2_bus_pkg.sv
src/dcache_line_ram.sv
src/dcache_set_state.sv
src/dcache_write_merge.sv
src/dcache_ctrl.sv
src/dcache_top.sv
sim/l2_model.sv
sim/dcache_tb.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/100ps --top-module dcache_tb \
   -f verilog.f -o dcache_sim \
   && ./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
